// File: rtl/cache_pkg.sv
// cache geometry constants
// controller state encoding
package cache_pkg;

  // processor word address and data word
  localparam int ADDR_W = 16;
  localparam int DATA_W = 16;

  // address split: tag 15:10, set 9:4, word 3:1, byte 0 (ignored)
  localparam int TAG_W  = 6;
  localparam int SET_W  = 6;
  localparam int WORD_W = 3;

  // 64 sets of 2 ways, 16-byte blocks
  localparam int NUM_SETS = 64;
  localparam int NUM_WAYS = 2;

  // words per block, also the number of beats in a fill burst
  localparam int BLOCK_WORDS = 8;

  // controller states
  typedef enum logic [2:0] {
    // waiting for a processor request
    ST_IDLE,
    // tag compare against the latched address
    ST_LOOKUP,
    // taking burst beats from memory
    ST_FILL,
    // one cycle to read the freshly filled word
    ST_REFILL_DONE,
    // waiting for the write acknowledge
    ST_WRITE_MEM,
    // done pulse
    ST_RESPOND
  } cache_state_e;

endpackage

// File: rtl/fill_if.sv
`timescale 1ns/1ps
// data array write port
// shared by controller, burst counter and data array
interface fill_if
  import cache_pkg::*;
();

  // one word written per cycle when we is high
  logic              we;
  logic              way;
  logic [SET_W-1:0]  set;
  // word index comes from the burst counter
  logic [WORD_W-1:0] word;
  logic [DATA_W-1:0] wdata;

  // controller owns enable, way, set and data
  modport ctrl (
    output we,
    output way,
    output set,
    output wdata
  );

  // counter owns the word index
  modport counter (
    output word
  );

  // array only listens
  modport array (
    input we,
    input way,
    input set,
    input word,
    input wdata
  );

endinterface

// File: rtl/meta_array.sv
`timescale 1ns/1ps
// tag, valid and LRU storage for both ways
// hit detection and victim selection
module meta_array
  import cache_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  // lookup address fields
  input  logic [SET_W-1:0] set,
  input  logic [TAG_W-1:0] tag,
  // LRU touch on a hit
  input  logic             update,
  // tag install at the end of a fill
  input  logic             fill,
  input  logic             way,
  output logic             hit,
  output logic             hit_way,
  output logic             victim_way
);

  // tags per way and set
  logic [TAG_W-1:0]    tag_q [NUM_WAYS][NUM_SETS];
  // one valid bit per way and set
  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
  // per set: index of the least recently used way
  logic [NUM_SETS-1:0] lru_q;
  // per-way compare result
  logic [NUM_WAYS-1:0] way_hit;

  // compare both ways in parallel
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = valid_q[w][set] && (tag_q[w][set] == tag);
    end
  end

  assign hit = |way_hit;
  // way 0 wins if both match, which cannot happen in normal use
  assign hit_way = ~way_hit[0] & way_hit[1];

  // empty way first, way 0 before way 1, else the LRU way
  always_comb begin
    if (!valid_q[0][set]) begin
      victim_way = 1'b0;
    end else if (!valid_q[1][set]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_q[set];
    end
  end

  // valid and LRU state
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '{default: '0};
      lru_q   <= '0;
    end else begin
      if (fill) begin
        valid_q[way][set] <= 1'b1;
      end
      // the touched way becomes MRU, so the other one is LRU
      if (update || fill) begin
        lru_q[set] <= ~way;
      end
    end
  end

  // tag store
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[way][set] <= tag;
    end
  end

endmodule

// File: rtl/data_array.sv
`timescale 1ns/1ps
// cache data storage, 2 ways x 64 sets x 8 words
// one write port from the fill interface, one registered read port
module data_array
  import cache_pkg::*;
(
  input  logic              clk,
  // read address
  input  logic [SET_W-1:0]  rd_set,
  input  logic              rd_way,
  input  logic [WORD_W-1:0] rd_word,
  // valid one cycle after the read address
  output logic [DATA_W-1:0] rdata,
  fill_if.array             fill
);

  // each way is 512 words, addressed as {set, word}
  logic [DATA_W-1:0] mem_q [NUM_WAYS][NUM_SETS*BLOCK_WORDS];

  // flat word addresses for both ports
  logic [SET_W+WORD_W-1:0] wr_idx;
  logic [SET_W+WORD_W-1:0] rd_idx;

  assign wr_idx = {fill.set, fill.word};
  assign rd_idx = {rd_set, rd_word};

  // write port
  // fill beats and write hits both land here
  always_ff @(posedge clk) begin
    if (fill.we) begin
      mem_q[fill.way][wr_idx] <= fill.wdata;
    end
  end

  // read port, registered every cycle
  // a write and read at the same edge returns the old word
  always_ff @(posedge clk) begin
    rdata <= mem_q[rd_way][rd_idx];
  end

endmodule

// File: rtl/burst_counter.sv
`timescale 1ns/1ps
// fill burst beat counter
// drives the array word index and flags the last beat
module burst_counter
  import cache_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  // clears the count at the start of a burst
  input  logic              start,
  // one memory beat
  input  logic              beat,
  // word of the pending request
  input  logic [WORD_W-1:0] req_word,
  // high while the controller is in a fill
  input  logic              filling,
  output logic              last,
  fill_if.counter           fill
);

  // beats taken so far in this burst
  logic [WORD_W-1:0] cnt_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else if (start) begin
      cnt_q <= '0;
    end else if (beat && filling) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // eighth beat, seen in the same cycle it arrives
  assign last = beat && filling && (cnt_q == WORD_W'(BLOCK_WORDS - 1));

  // beats land in word order, other writes use the request word
  assign fill.word = filling ? cnt_q : req_word;

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ps
// cache controller FSM
// lookup, read-miss fill, write-through and done
module cache_ctrl
  import cache_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  // processor request
  input  logic              req,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  // meta array lookup result and update controls
  input  logic              hit,
  input  logic              hit_way,
  input  logic              victim_way,
  output logic              meta_update,
  output logic              meta_fill,
  output logic              meta_way,
  output logic [ADDR_W-1:0] req_addr,
  // burst counter
  output logic              burst_start,
  output logic              filling,
  input  logic              burst_last,
  // memory side
  input  logic              mem_valid,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic              busy,
  output logic              done,
  output logic              mem_rd,
  output logic              mem_wr,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  fill_if.ctrl              fill
);

  cache_state_e state_q;
  cache_state_e state_d;

  // latched request
  logic              we_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  // way being filled on a read miss
  logic              victim_q;
  // memory command pulses
  logic              mem_rd_q;
  logic              mem_wr_q;
  logic              lookup;

  assign lookup = (state_q == ST_LOOKUP);

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:        if (req) state_d = ST_LOOKUP;
      ST_LOOKUP: begin
        // writes always go to memory, hit or not
        if (we_q) begin
          state_d = ST_WRITE_MEM;
        end else if (hit) begin
          state_d = ST_RESPOND;
        end else begin
          state_d = ST_FILL;
        end
      end
      ST_FILL:        if (burst_last) state_d = ST_REFILL_DONE;
      // array read of the requested word happens here
      ST_REFILL_DONE: state_d = ST_RESPOND;
      ST_WRITE_MEM:   if (mem_valid) state_d = ST_RESPOND;
      ST_RESPOND:     state_d = ST_IDLE;
      default:        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= ST_IDLE;
      we_q     <= 1'b0;
      mem_rd_q <= 1'b0;
      mem_wr_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      if (state_q == ST_IDLE && req) begin
        we_q <= we;
      end
      // both pulse the cycle after lookup
      mem_rd_q <= burst_start;
      mem_wr_q <= lookup && we_q;
    end
  end

  // request payload and victim
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && req) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
    if (burst_start) begin
      victim_q <= victim_way;
    end
  end

  // read miss detected in lookup
  assign burst_start = lookup && !we_q && !hit;
  assign filling     = (state_q == ST_FILL);

  // LRU touch on any hit, tag install with the last beat
  assign meta_update = lookup && hit;
  assign meta_fill   = filling && burst_last;
  assign meta_way    = filling ? victim_q : hit_way;
  assign req_addr    = addr_q;

  // array writes: each fill beat, or a write hit during lookup
  assign fill.we    = (filling && mem_valid) || (lookup && we_q && hit);
  assign fill.way   = filling ? victim_q : hit_way;
  assign fill.set   = addr_q[WORD_W+1 +: SET_W];
  assign fill.wdata = filling ? mem_rdata : wdata_q;

  // processor handshake
  assign busy = (state_q != ST_IDLE);
  assign done = (state_q == ST_RESPOND);

  // memory commands
  // block aligned for a burst read, full word address for a write
  assign mem_rd    = mem_rd_q;
  assign mem_wr    = mem_wr_q;
  assign mem_addr  = we_q ? addr_q : {addr_q[ADDR_W-1:WORD_W+1], {(WORD_W+1){1'b0}}};
  assign mem_wdata = wdata_q;

endmodule

// File: rtl/cache_top.sv
`timescale 1ns/1ps
// 2 KB 2-way set-associative write-through cache
// address split and block wiring
module cache_top
  import cache_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  // processor side
  input  logic              req,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata,
  output logic              busy,
  output logic              done,
  // memory side
  output logic              mem_rd,
  output logic              mem_wr,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  input  logic [DATA_W-1:0] mem_rdata,
  input  logic              mem_valid
);

  // latched request address and its fields
  logic [ADDR_W-1:0] req_addr;
  logic [TAG_W-1:0]  req_tag;
  logic [SET_W-1:0]  req_set;
  logic [WORD_W-1:0] req_word;

  // meta array handshake
  logic hit;
  logic hit_way;
  logic victim_way;
  logic meta_update;
  logic meta_fill;
  logic meta_way;

  // burst counter handshake
  logic burst_start;
  logic burst_last;
  logic filling;

  // bit 0 is the byte within a word and is dropped
  assign req_tag  = req_addr[ADDR_W-1 -: TAG_W];
  assign req_set  = req_addr[WORD_W+1 +: SET_W];
  assign req_word = req_addr[1 +: WORD_W];

  fill_if i_fill ();

  cache_ctrl i_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (req),
    .we          (we),
    .addr        (addr),
    .wdata       (wdata),
    .hit         (hit),
    .hit_way     (hit_way),
    .victim_way  (victim_way),
    .meta_update (meta_update),
    .meta_fill   (meta_fill),
    .meta_way    (meta_way),
    .req_addr    (req_addr),
    .burst_start (burst_start),
    .filling     (filling),
    .burst_last  (burst_last),
    .mem_valid   (mem_valid),
    .mem_rdata   (mem_rdata),
    .busy        (busy),
    .done        (done),
    .mem_rd      (mem_rd),
    .mem_wr      (mem_wr),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .fill        (i_fill.ctrl)
  );

  burst_counter i_burst (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (burst_start),
    .beat     (mem_valid),
    .req_word (req_word),
    .filling  (filling),
    .last     (burst_last),
    .fill     (i_fill.counter)
  );

  meta_array i_meta (
    .clk        (clk),
    .arst_n     (arst_n),
    .set        (req_set),
    .tag        (req_tag),
    .update     (meta_update),
    .fill       (meta_fill),
    .way        (meta_way),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  // after a fill the new tag hits, so hit_way points at the filled way
  data_array i_data (
    .clk     (clk),
    .rd_set  (req_set),
    .rd_way  (hit_way),
    .rd_word (req_word),
    .rdata   (rdata),
    .fill    (i_fill.array)
  );

endmodule

// File: tb/cache_model.svh
// memory images for the responder and the reference model
// reference cache state and prediction of data and misses
// responder memory, written by mem_wr beats
logic [DATA_W-1:0] mem_img [0:32767];
// expected memory, written by the model
logic [DATA_W-1:0] ref_mem [0:32767];
// mirrored tags, valid bits and LRU way per set
logic [TAG_W-1:0]  ref_tag   [NUM_WAYS][NUM_SETS];
logic              ref_valid [NUM_WAYS][NUM_SETS];
logic              ref_lru   [NUM_SETS];

// initial memory contents, odd multiplier so every address bit matters
function automatic logic [DATA_W-1:0] fill_word(input int idx);
  return 16'(idx * 40503 + (idx >> 11));
endfunction

task automatic init_model();
  for (int i = 0; i < 32768; i++) begin
    mem_img[i] = fill_word(i);
    ref_mem[i] = fill_word(i);
  end
  for (int s = 0; s < NUM_SETS; s++) begin
    ref_lru[s] = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      ref_valid[w][s] = 1'b0;
      ref_tag[w][s]   = '0;
    end
  end
endtask

// one access against the mirror: returns the expected word
// miss is high only for a read that needs a burst
function automatic logic [DATA_W-1:0] predict(input logic [ADDR_W-1:0] a, input logic wr,
                                               input logic [DATA_W-1:0] d, output logic miss);
  logic [SET_W-1:0] set_idx;
  logic [TAG_W-1:0] tag;
  logic             hit;
  logic             way;
  set_idx = a[9:4];
  tag     = a[15:10];
  hit     = 1'b0;
  way     = 1'b0;
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (ref_valid[w][set_idx] && ref_tag[w][set_idx] == tag) begin
      hit = 1'b1;
      way = w[0];
    end
  end
  miss = !hit && !wr;
  // any hit makes its way MRU
  if (hit) begin
    ref_lru[set_idx] = ~way;
  end else if (!wr) begin
    // invalid way 0, then invalid way 1, else LRU
    if (!ref_valid[0][set_idx]) way = 1'b0;
    else if (!ref_valid[1][set_idx]) way = 1'b1;
    else way = ref_lru[set_idx];
    ref_valid[way][set_idx] = 1'b1;
    ref_tag[way][set_idx]   = tag;
    ref_lru[set_idx]        = ~way;
  end
  // write-through, no allocate
  if (wr) ref_mem[a[15:1]] = d;
  return ref_mem[a[15:1]];
endfunction

// File: tb/cache_tb.sv
`timescale 1ns/1ps
// cache testbench: clock, reset, memory responder, directed and random tests
// compare process for memory commands and done, watchdog
module cache_tb
  import cache_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 4;
  localparam int NUM_RANDOM = 200;
  // directed accesses stay below 20
  localparam int NUM_OPS    = NUM_RANDOM + 20;
  localparam int MAX_GAP    = 3;
  // worst case per access: request, 8 beats with full gaps, overhead
  localparam int OP_CYCLES  = 2 + BLOCK_WORDS * (MAX_GAP + 1) + 6;

  logic              clk;
  logic              arst_n;
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;
  logic              busy;
  logic              done;
  logic              mem_rd;
  logic              mem_wr;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic [DATA_W-1:0] mem_rdata;
  logic              mem_valid;

  integer seed = 32'h28b1_13b6;

  // expected response of the request in flight
  string             test_name;
  logic [DATA_W-1:0] exp_rdata;
  logic [ADDR_W-1:0] exp_block;
  logic [ADDR_W-1:0] exp_addr;
  logic [DATA_W-1:0] exp_wdata;
  logic              exp_read;
  int                exp_rd;
  int                exp_wr;
  // command counts per request and over the run
  int                rd_cnt = 0;
  int                wr_cnt = 0;
  int                total_rd = 0;
  int                total_miss = 0;

  `include "cache_model.svh"

  cache_top i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .rdata     (rdata),
    .busy      (busy),
    .done      (done),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_valid (mem_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  // memory: 8-beat burst per mem_rd, one acknowledge beat per mem_wr
  // random idle gaps before every beat
  initial begin
    int          gap;
    logic [14:0] base;
    mem_valid = 1'b0;
    mem_rdata = '0;
    forever begin
      @(negedge clk);
      if (mem_rd) begin
        base = mem_addr[15:1];
        for (int i = 0; i < BLOCK_WORDS; i++) begin
          gap = {$random(seed)} % (MAX_GAP + 1);
          mem_valid = 1'b0;
          repeat (gap) @(negedge clk);
          mem_valid = 1'b1;
          mem_rdata = mem_img[base + 15'(i)];
          @(negedge clk);
        end
        mem_valid = 1'b0;
      end else if (mem_wr) begin
        mem_img[mem_addr[15:1]] = mem_wdata;
        gap = {$random(seed)} % (MAX_GAP + 1);
        repeat (gap) @(negedge clk);
        mem_valid = 1'b1;
        @(negedge clk);
        mem_valid = 1'b0;
      end
    end
  end

  // compare process, sampled away from the clock edge
  always @(negedge clk) begin
    if (mem_rd) begin
      rd_cnt   = rd_cnt + 1;
      total_rd = total_rd + 1;
      check_value({test_name, " mem_rd addr"}, exp_block, mem_addr);
    end
    if (mem_wr) begin
      wr_cnt = wr_cnt + 1;
      check_value({test_name, " mem_wr addr"}, exp_addr, mem_addr);
      check_value({test_name, " mem_wr data"}, exp_wdata, mem_wdata);
    end
    if (done) begin
      check_value({test_name, " mem_rd count"}, exp_rd, rd_cnt);
      check_value({test_name, " mem_wr count"}, exp_wr, wr_cnt);
      if (exp_read) check_value({test_name, " rdata"}, exp_rdata, rdata);
    end
  end

  // one request, up to its done
  // want_miss below zero means the directed test has no opinion
  task automatic access(input string name, input logic wr, input logic [ADDR_W-1:0] a,
                        input logic [DATA_W-1:0] d, input int want_miss);
    logic miss;
    int   cycles;
    @(negedge clk);
    test_name = name;
    exp_rdata = predict(a, wr, d, miss);
    exp_read  = !wr;
    exp_rd    = miss;
    exp_wr    = wr;
    exp_block = {a[15:4], 4'h0};
    exp_addr  = a;
    exp_wdata = d;
    rd_cnt    = 0;
    wr_cnt    = 0;
    if (miss) total_miss = total_miss + 1;
    if (want_miss >= 0) check_value({name, " model miss"}, want_miss, miss);
    req   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = d;
    @(negedge clk);
    req    = 1'b0;
    cycles = 1;
    check_value({name, " busy"}, 1, busy);
    while (!done) begin
      @(negedge clk);
      cycles++;
    end
    // a read hit answers 2 cycles after req
    if (!wr && !miss) check_value({name, " hit latency"}, 2, cycles);
  endtask

  initial begin
    logic [31:0] r;
    req    = 1'b0;
    we     = 1'b0;
    addr   = '0;
    wdata  = '0;
    arst_n = 1'b0;
    init_model();
    repeat (RST_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    check_value("reset busy", 0, busy);
    check_value("reset done", 0, done);
    check_value("reset mem_rd", 0, mem_rd);
    check_value("reset mem_wr", 0, mem_wr);
    // cold read from the middle of a block, then the whole block hits
    access("cold read", 1'b0, 16'h0046, '0, 1);
    for (int w = 0; w < BLOCK_WORDS; w++) begin
      access("block hit", 1'b0, 16'h0040 + 16'(2 * w), '0, 0);
    end
    // A, B, C share set 4; C evicts B since A was used last
    access("lru read A", 1'b0, 16'h004a, '0, 0);
    access("lru read B", 1'b0, 16'h0442, '0, 1);
    access("lru read A again", 1'b0, 16'h0040, '0, 0);
    access("lru read C", 1'b0, 16'h084e, '0, 1);
    access("lru A kept", 1'b0, 16'h0044, '0, 0);
    access("lru B evicted", 1'b0, 16'h0448, '0, 1);
    // write hit on A, write miss on an uncached block
    access("write hit", 1'b1, 16'h004c, 16'hbeef, 0);
    access("write miss", 1'b1, 16'h1234, 16'h5a5a, 0);
    access("read after write hit", 1'b0, 16'h004c, '0, 0);
    access("read after write miss", 1'b0, 16'h1234, '0, 1);
    // random mix over tags 0-3 and sets 0-3
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $random(seed);
      access("random", r[16], r[15:0] & 16'h0c3e, 16'($random(seed)), -1);
    end
    check_value("total miss count", total_miss, total_rd);
    $display("Done: no errors");
    $finish;
  end

  // watchdog sized for every access at worst-case memory timing
  initial begin
    #((RST_CYCLES + NUM_OPS * OP_CYCLES) * CLK_PERIOD);
    $display("timeout: the run did not reach its end in time");
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: cache_sys.f
+incdir+tb
rtl/cache_pkg.sv
rtl/fill_if.sv
rtl/meta_array.sv
rtl/data_array.sv
rtl/burst_counter.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
tb/cache_tb.sv
